/* pong_pkg.sv */
package pong_pkg;

  // **************************************************
  // raster and colour types
  // **************************************************

  typedef logic [9:0] coord_t;   // column or row index.
  typedef logic [2:0] rgb_t;     // one colour channel.

  typedef struct packed {
    logic up;
    logic down;
  } paddle_cmd_t;

  // hsync and vsync are high inside the active columns and rows.
  typedef struct packed {
    coord_t col;
    coord_t row;
    logic   hsync;
    logic   vsync;
  } scan_t;

  typedef struct packed {
    rgb_t red;
    rgb_t grn;
    rgb_t blu;
  } pixel_t;

  typedef enum logic {
    ST_IDLE,
    ST_PLAY
  } game_state_e;

endpackage

/* debounce_switch.sv */
`timescale 1ns/100ps

module debounce_switch #(
  parameter int DEBOUNCE_LIMIT = 250000
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_switch,
  output logic o_switch
);

  localparam int CW = $clog2(DEBOUNCE_LIMIT + 1);

  logic [CW-1:0] r_count;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_count  <= '0;
      o_switch <= 1'b0;
    end else if (i_switch != o_switch && r_count < CW'(DEBOUNCE_LIMIT - 1)) begin
      r_count <= r_count + 1'b1;                 // input held away from the stored level.
    end else if (r_count == CW'(DEBOUNCE_LIMIT - 1)) begin
      o_switch <= i_switch;
      r_count  <= '0;
    end else begin
      r_count <= '0;                             // bounced back, start over.
    end
  end

endmodule

/* uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 217
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_serial,
  output byte  o_byte,
  output logic o_valid
);

  localparam int CW = $clog2(CLKS_PER_BIT);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_CLEANUP
  } rx_state_e;

  rx_state_e     r_state;
  logic [CW-1:0] r_clk_count;
  logic [2:0]    r_bit_idx;

  // **************************************************
  // 8N1 receive state machine
  // **************************************************

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_state     <= RX_IDLE;
      r_clk_count <= '0;
      r_bit_idx   <= '0;
      o_valid     <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      case (r_state)
        RX_IDLE: begin
          r_clk_count <= '0;
          r_bit_idx   <= '0;
          if (!i_serial) begin
            r_state <= RX_START;
          end
        end
        RX_START: begin
          if (r_clk_count == CW'((CLKS_PER_BIT - 1) / 2)) begin
            r_clk_count <= '0;
            r_state     <= i_serial ? RX_IDLE : RX_DATA;   // a glitch goes back to idle.
          end else begin
            r_clk_count <= r_clk_count + 1'b1;
          end
        end
        RX_DATA: begin
          if (r_clk_count < CW'(CLKS_PER_BIT - 1)) begin
            r_clk_count <= r_clk_count + 1'b1;
          end else begin
            r_clk_count       <= '0;
            o_byte[r_bit_idx] <= i_serial;                  // lsb arrives first.
            r_bit_idx         <= r_bit_idx + 1'b1;
            if (r_bit_idx == 3'd7) begin
              r_state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (r_clk_count < CW'(CLKS_PER_BIT - 1)) begin
            r_clk_count <= r_clk_count + 1'b1;
          end else begin
            r_clk_count <= '0;
            o_valid     <= i_serial;                        // framing error gives no pulse.
            r_state     <= RX_CLEANUP;
          end
        end
        RX_CLEANUP: begin
          if (i_serial) begin
            r_state <= RX_IDLE;                             // wait out a low stop bit.
          end
        end
        default: r_state <= RX_IDLE;
      endcase
    end
  end

endmodule

/* sync_pulse.sv */
`timescale 1ns/100ps

module sync_pulse
  import pong_pkg::*;
#(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  logic  i_clk,
  input  logic  i_reset,
  output scan_t o_scan
);

  localparam coord_t COL_LAST = coord_t'(TOTAL_COLS - 1);
  localparam coord_t ROW_LAST = coord_t'(TOTAL_ROWS - 1);

  coord_t r_col;
  coord_t r_row;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_col <= '0;
      r_row <= '0;
    end else if (r_col == COL_LAST) begin
      r_col <= '0;
      r_row <= (r_row == ROW_LAST) ? '0 : r_row + 1'b1;
    end else begin
      r_col <= r_col + 1'b1;
    end
  end

  always_comb begin
    o_scan.col   = r_col;
    o_scan.row   = r_row;
    o_scan.hsync = (r_col < coord_t'(ACTIVE_COLS));
    o_scan.vsync = (r_row < coord_t'(ACTIVE_ROWS));
  end

endmodule

/* pong_paddle.sv */
`timescale 1ns/100ps

module pong_paddle
  import pong_pkg::*;
#(
  parameter int ACTIVE_ROWS   = 480,
  parameter int PADDLE_HEIGHT = 60
) (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_frame,
  input  paddle_cmd_t i_cmd,
  output coord_t      o_top
);

  localparam coord_t TOP_MAX = coord_t'(ACTIVE_ROWS - PADDLE_HEIGHT);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_top <= TOP_MAX >> 1;                     // start centred.
    end else if (i_frame) begin
      if (i_cmd.up && !i_cmd.down && o_top != '0) begin
        o_top <= o_top - 1'b1;
      end else if (i_cmd.down && !i_cmd.up && o_top < TOP_MAX) begin
        o_top <= o_top + 1'b1;
      end
    end
  end

endmodule

/* game_main.sv */
`timescale 1ns/100ps

module game_main
  import pong_pkg::*;
#(
  parameter int TOTAL_COLS    = 800,
  parameter int TOTAL_ROWS    = 525,
  parameter int ACTIVE_COLS   = 640,
  parameter int ACTIVE_ROWS   = 480,
  parameter int PADDLE_HEIGHT = 60
) (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_start,
  input  paddle_cmd_t i_cmd_1,
  input  paddle_cmd_t i_cmd_2,
  input  scan_t       i_scan,
  output scan_t       o_scan,
  output pixel_t      o_pixel
);

  localparam coord_t BALL_COL0 = coord_t'(ACTIVE_COLS / 2);
  localparam coord_t BALL_ROW0 = coord_t'(ACTIVE_ROWS / 2);
  localparam coord_t COL_LEFT  = coord_t'(1);
  localparam coord_t COL_RIGHT = coord_t'(ACTIVE_COLS - 2);
  localparam coord_t PAD_COL_2 = coord_t'(ACTIVE_COLS - 1);
  localparam coord_t ROW_LAST  = coord_t'(ACTIVE_ROWS - 1);

  game_state_e r_state;
  coord_t      r_ball_col;
  coord_t      r_ball_row;
  logic        r_dir_col;                        // 1 moves toward higher columns.
  logic        r_dir_row;
  logic        w_frame;
  logic        w_dir_col;
  logic        w_dir_row;
  logic        w_miss;
  coord_t      w_top_1;
  coord_t      w_top_2;
  pixel_t      w_pixel;

  function automatic logic covers(input coord_t row, input coord_t top);
    return (row >= top) && (32'(row) < 32'(top) + PADDLE_HEIGHT);
  endfunction

  assign w_frame = (i_scan.col == coord_t'(TOTAL_COLS - 1)) &&
                   (i_scan.row == coord_t'(TOTAL_ROWS - 1));

  pong_paddle #(
    .ACTIVE_ROWS  (ACTIVE_ROWS),
    .PADDLE_HEIGHT(PADDLE_HEIGHT)
  ) paddle_1_inst (
    .i_clk  (i_clk),
    .i_reset(i_reset),
    .i_frame(w_frame),
    .i_cmd  (i_cmd_1),
    .o_top  (w_top_1)
  );

  pong_paddle #(
    .ACTIVE_ROWS  (ACTIVE_ROWS),
    .PADDLE_HEIGHT(PADDLE_HEIGHT)
  ) paddle_2_inst (
    .i_clk  (i_clk),
    .i_reset(i_reset),
    .i_frame(w_frame),
    .i_cmd  (i_cmd_2),
    .o_top  (w_top_2)
  );

  // **************************************************
  // ball direction and state machine
  // **************************************************

  always_comb begin
    w_dir_row = r_dir_row;
    w_dir_col = r_dir_col;
    w_miss    = 1'b0;
    if (r_ball_row == '0) begin
      w_dir_row = 1'b1;
    end else if (r_ball_row == ROW_LAST) begin
      w_dir_row = 1'b0;
    end
    if (r_ball_col == COL_LEFT) begin
      if (covers(r_ball_row, w_top_1)) w_dir_col = 1'b1;
      else w_miss = 1'b1;
    end else if (r_ball_col == COL_RIGHT) begin
      if (covers(r_ball_row, w_top_2)) w_dir_col = 1'b0;
      else w_miss = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_state    <= ST_IDLE;
      r_ball_col <= BALL_COL0;
      r_ball_row <= BALL_ROW0;
      r_dir_col  <= 1'b1;
      r_dir_row  <= 1'b1;
    end else begin
      case (r_state)
        ST_IDLE: begin
          r_ball_col <= BALL_COL0;
          r_ball_row <= BALL_ROW0;
          if (i_start) begin
            r_state   <= ST_PLAY;
            r_dir_col <= 1'b1;
            r_dir_row <= 1'b1;
          end
        end
        ST_PLAY: begin
          if (w_frame && w_miss) begin
            r_state    <= ST_IDLE;
            r_ball_col <= BALL_COL0;
            r_ball_row <= BALL_ROW0;
          end else if (w_frame) begin
            r_dir_col  <= w_dir_col;
            r_dir_row  <= w_dir_row;
            r_ball_col <= w_dir_col ? r_ball_col + 1'b1 : r_ball_col - 1'b1;
            r_ball_row <= w_dir_row ? r_ball_row + 1'b1 : r_ball_row - 1'b1;
          end
        end
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  // **************************************************
  // drawing
  // **************************************************

  always_comb begin
    w_pixel = '0;
    if ((i_scan.col == '0 && covers(i_scan.row, w_top_1)) ||
        (i_scan.col == PAD_COL_2 && covers(i_scan.row, w_top_2))) begin
      w_pixel = '1;
    end else if (i_scan.col == r_ball_col && i_scan.row == r_ball_row) begin
      w_pixel.grn = '1;
    end
  end

  always_ff @(posedge i_clk) begin
    o_scan  <= i_scan;                           // keeps scan aligned with the pixel.
    o_pixel <= w_pixel;
  end

endmodule

/* sync_porch.sv */
`timescale 1ns/100ps

module sync_porch
  import pong_pkg::*;
#(
  parameter int TOTAL_COLS    = 800,
  parameter int TOTAL_ROWS    = 525,
  parameter int ACTIVE_COLS   = 640,
  parameter int ACTIVE_ROWS   = 480,
  parameter int FRONT_PORCH_H = 16,
  parameter int SYNC_WIDTH_H  = 96,
  parameter int FRONT_PORCH_V = 10,
  parameter int SYNC_WIDTH_V  = 2
) (
  input  logic   i_clk,
  input  logic   i_reset,
  input  scan_t  i_scan,
  input  pixel_t i_pixel,
  output logic   o_hsync,
  output logic   o_vsync,
  output rgb_t   o_red,
  output rgb_t   o_grn,
  output rgb_t   o_blu
);

  localparam int     H_END_RAW    = ACTIVE_COLS + FRONT_PORCH_H + SYNC_WIDTH_H;
  localparam int     V_END_RAW    = ACTIVE_ROWS + FRONT_PORCH_V + SYNC_WIDTH_V;
  localparam coord_t H_SYNC_START = coord_t'(ACTIVE_COLS + FRONT_PORCH_H);
  localparam coord_t V_SYNC_START = coord_t'(ACTIVE_ROWS + FRONT_PORCH_V);
  localparam coord_t H_SYNC_END   = coord_t'((H_END_RAW > TOTAL_COLS) ? TOTAL_COLS : H_END_RAW);
  localparam coord_t V_SYNC_END   = coord_t'((V_END_RAW > TOTAL_ROWS) ? TOTAL_ROWS : V_END_RAW);

  logic w_hpulse;
  logic w_vpulse;
  logic w_active;

  assign w_hpulse = (i_scan.col >= H_SYNC_START) && (i_scan.col < H_SYNC_END);
  assign w_vpulse = (i_scan.row >= V_SYNC_START) && (i_scan.row < V_SYNC_END);
  assign w_active = i_scan.hsync && i_scan.vsync;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_hsync <= 1'b1;                           // sync is active low.
      o_vsync <= 1'b1;
      o_red   <= '0;
      o_grn   <= '0;
      o_blu   <= '0;
    end else begin
      o_hsync <= ~w_hpulse;
      o_vsync <= ~w_vpulse;
      o_red   <= w_active ? i_pixel.red : '0;
      o_grn   <= w_active ? i_pixel.grn : '0;
      o_blu   <= w_active ? i_pixel.blu : '0;
    end
  end

endmodule

/* pong_main.sv */
`timescale 1ns/100ps

module pong_main
  import pong_pkg::*;
#(
  parameter int TOTAL_COLS     = 800,
  parameter int TOTAL_ROWS     = 525,
  parameter int ACTIVE_COLS    = 640,
  parameter int ACTIVE_ROWS    = 480,
  parameter int FRONT_PORCH_H  = 16,
  parameter int SYNC_WIDTH_H   = 96,
  parameter int FRONT_PORCH_V  = 10,
  parameter int SYNC_WIDTH_V   = 2,
  parameter int PADDLE_HEIGHT  = 60,
  parameter int DEBOUNCE_LIMIT = 250000,
  parameter int CLKS_PER_BIT   = 217
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_switch_1,
  input  logic i_switch_2,
  input  logic i_switch_3,
  input  logic i_switch_4,
  input  logic i_uart_rx,
  output logic o_vga_hsync,
  output logic o_vga_vsync,
  output rgb_t o_vga_red,
  output rgb_t o_vga_grn,
  output rgb_t o_vga_blu
);

  wire paddle_cmd_t w_cmd_1;
  wire paddle_cmd_t w_cmd_2;
  wire logic        w_start;
  wire scan_t       w_scan;
  wire scan_t       w_scan_game;
  wire pixel_t      w_pixel;

  // **************************************************
  // decode
  // **************************************************

  debounce_switch #(.DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)) switch_1_inst (
    .i_clk(i_clk), .i_reset(i_reset), .i_switch(i_switch_1), .o_switch(w_cmd_1.up));

  debounce_switch #(.DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)) switch_2_inst (
    .i_clk(i_clk), .i_reset(i_reset), .i_switch(i_switch_2), .o_switch(w_cmd_1.down));

  debounce_switch #(.DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)) switch_3_inst (
    .i_clk(i_clk), .i_reset(i_reset), .i_switch(i_switch_3), .o_switch(w_cmd_2.up));

  debounce_switch #(.DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)) switch_4_inst (
    .i_clk(i_clk), .i_reset(i_reset), .i_switch(i_switch_4), .o_switch(w_cmd_2.down));

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_serial(i_uart_rx),
    .o_byte  (),                                 // any byte serves the ball.
    .o_valid (w_start)
  );

  // **************************************************
  // execute
  // **************************************************

  sync_pulse #(
    .TOTAL_COLS(TOTAL_COLS), .TOTAL_ROWS(TOTAL_ROWS),
    .ACTIVE_COLS(ACTIVE_COLS), .ACTIVE_ROWS(ACTIVE_ROWS)
  ) sync_pulse_inst (
    .i_clk(i_clk), .i_reset(i_reset), .o_scan(w_scan));

  game_main #(
    .TOTAL_COLS(TOTAL_COLS), .TOTAL_ROWS(TOTAL_ROWS),
    .ACTIVE_COLS(ACTIVE_COLS), .ACTIVE_ROWS(ACTIVE_ROWS),
    .PADDLE_HEIGHT(PADDLE_HEIGHT)
  ) game_main_inst (
    .i_clk  (i_clk),
    .i_reset(i_reset),
    .i_start(w_start),
    .i_cmd_1(w_cmd_1),
    .i_cmd_2(w_cmd_2),
    .i_scan (w_scan),
    .o_scan (w_scan_game),
    .o_pixel(w_pixel)
  );

  // **************************************************
  // result
  // **************************************************

  sync_porch #(
    .TOTAL_COLS(TOTAL_COLS), .TOTAL_ROWS(TOTAL_ROWS),
    .ACTIVE_COLS(ACTIVE_COLS), .ACTIVE_ROWS(ACTIVE_ROWS),
    .FRONT_PORCH_H(FRONT_PORCH_H), .SYNC_WIDTH_H(SYNC_WIDTH_H),
    .FRONT_PORCH_V(FRONT_PORCH_V), .SYNC_WIDTH_V(SYNC_WIDTH_V)
  ) sync_porch_inst (
    .i_clk  (i_clk),
    .i_reset(i_reset),
    .i_scan (w_scan_game),
    .i_pixel(w_pixel),
    .o_hsync(o_vga_hsync),
    .o_vsync(o_vga_vsync),
    .o_red  (o_vga_red),
    .o_grn  (o_vga_grn),
    .o_blu  (o_vga_blu)
  );

endmodule

/* pong_main_assert.sv */
`timescale 1ns/100ps

module pong_main_assert
  import pong_pkg::*;
#(
  parameter int SYNC_WIDTH_H = 96
) (
  input logic        i_clk,
  input logic        i_reset,
  input logic        i_hsync,
  input logic        i_vsync,
  input logic [8:0]  i_colour,
  input logic        i_start,
  input game_state_e i_state
);

  int r_low_count;

  always_ff @(posedge i_clk) begin
    if (i_reset || i_hsync) r_low_count <= 0;
    else r_low_count <= r_low_count + 1;       // cycles spent inside the hsync pulse.
  end

  // **************************************************
  // properties
  // **************************************************

  hsync_width: assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(i_hsync) |-> r_low_count == SYNC_WIDTH_H) else $error("hsync pulse width");

  blank_in_sync: assert property (@(posedge i_clk) disable iff (i_reset)
    (!i_hsync || !i_vsync) |-> i_colour == 9'd0) else $error("colour during sync");

  start_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
    i_start |=> !i_start) else $error("start pulse too long");

  legal_state: assert property (@(posedge i_clk) disable iff (i_reset)
    i_state == ST_IDLE || i_state == ST_PLAY) else $error("illegal game state");

endmodule

bind pong_main pong_main_assert #(.SYNC_WIDTH_H(SYNC_WIDTH_H)) pong_main_assert_inst (
  .i_clk   (i_clk),
  .i_reset (i_reset),
  .i_hsync (o_vga_hsync),
  .i_vsync (o_vga_vsync),
  .i_colour({o_vga_red, o_vga_grn, o_vga_blu}),
  .i_start (w_start),
  .i_state (game_main_inst.r_state)
);

/* pong_main_tb.sv */
`timescale 1ns/100ps

module pong_main_tb;

  localparam int TC = 40;
  localparam int TR = 30;
  localparam int AC = 32;
  localparam int AR = 24;
  localparam int H_START = AC + 2;                     // first column of the hsync pulse.
  localparam int V_START = AR + 2;
  localparam int PH = 6;
  localparam int FRAME_CYCLES = TC * TR;
  // the tests run for about 130 frames and the limit leaves some margin.
  localparam int LIMIT_CYCLES = 160 * FRAME_CYCLES;

  logic i_clk, i_reset, i_uart_rx;
  logic i_switch_1, i_switch_2, i_switch_3, i_switch_4;
  logic o_vga_hsync, o_vga_vsync;
  logic [2:0] o_vga_red, o_vga_grn, o_vga_blu;

  int errors, test_errors, tests_run, tests_failed, cycles, seed;
  int tb_col, tb_row, frame_count, line_len, last_line_len, low_width, last_low_width;
  int lines, last_lines, outside_errors, p1_top, p1_len, p2_top, p2_len;
  int ball_col, ball_row, ball_count, stray_count, m_col, m_row, m_dc, m_dr, m_play, t1, t2;
  logic h_synced, v_synced, prev_hs, prev_vs;
  logic [8:0] cap [0:AR-1][0:AC-1];
  logic [8:0] snap [0:AR-1][0:AC-1];

  pong_main #(
    .TOTAL_COLS(TC), .TOTAL_ROWS(TR), .ACTIVE_COLS(AC), .ACTIVE_ROWS(AR),
    .FRONT_PORCH_H(2), .SYNC_WIDTH_H(4), .FRONT_PORCH_V(2), .SYNC_WIDTH_V(2),
    .PADDLE_HEIGHT(PH), .DEBOUNCE_LIMIT(8), .CLKS_PER_BIT(4)
  ) pong_main_inst (.*);

  always #10 i_clk = ~i_clk;

  task automatic check(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("error %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  // **************************************************
  // frame capture from the sync edges
  // **************************************************

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= LIMIT_CYCLES) begin
      $display("timeout: the run took longer than its cycle budget");
      $display("Result: FAILED");
      $finish;
    end
    if (i_reset) begin
      h_synced <= 1'b0;
      v_synced <= 1'b0;
      prev_hs  <= 1'b1;
      prev_vs  <= 1'b1;
    end else begin
      line_len = line_len + 1;
      if (!o_vga_hsync) low_width = low_width + 1;
      if (prev_hs && !o_vga_hsync) begin
        tb_col = H_START;
        if (h_synced) last_line_len = line_len;
        line_len = 0;
        lines = lines + 1;
        h_synced <= 1'b1;
      end else if (tb_col == TC - 1) begin
        tb_col = 0;
        tb_row = (tb_row == TR - 1) ? 0 : tb_row + 1;
      end else begin
        tb_col = tb_col + 1;
      end
      if (!prev_hs && o_vga_hsync) begin
        last_low_width = low_width;
        low_width = 0;
      end
      if (prev_vs && !o_vga_vsync) begin
        tb_row = V_START;
        if (v_synced) last_lines = lines;
        lines = 0;
        for (int r = 0; r < AR; r++) begin
          for (int c = 0; c < AC; c++) begin
            snap[r][c] = cap[r][c];
          end
        end
        frame_count = frame_count + 1;
        v_synced <= 1'b1;
      end
      if (h_synced && v_synced) begin
        if (tb_col < AC && tb_row < AR) begin
          cap[tb_row][tb_col] = {o_vga_red, o_vga_grn, o_vga_blu};
        end else if ({o_vga_red, o_vga_grn, o_vga_blu} != 9'd0) begin
          outside_errors = outside_errors + 1;   // colour seen in the blanking area.
        end
      end
      prev_hs <= o_vga_hsync;
      prev_vs <= o_vga_vsync;
    end
  end

  task automatic wait_frames(input int n);
    int target;
    target = frame_count + n;
    while (frame_count < target) @(negedge i_clk);
  endtask

  task automatic analyze_frame();
    p1_len = 0;
    p2_len = 0;
    ball_count = 0;
    stray_count = 0;
    p1_top = -1;
    p2_top = -1;
    for (int r = 0; r < AR; r++) begin
      if (snap[r][0] == 9'h1ff) begin
        if (p1_len == 0) p1_top = r;
        p1_len++;
      end else if (snap[r][0] != 9'd0) begin
        stray_count++;
      end
      if (snap[r][AC-1] == 9'h1ff) begin
        if (p2_len == 0) p2_top = r;
        p2_len++;
      end else if (snap[r][AC-1] != 9'd0) begin
        stray_count++;
      end
      for (int c = 1; c < AC - 1; c++) begin
        if (snap[r][c] == 9'b000_111_000) begin
          ball_count++;
          ball_col = c;
          ball_row = r;
        end else if (snap[r][c] != 9'd0) begin
          stray_count++;                         // only the ball is drawn between the paddles.
        end
      end
    end
  endtask

  task automatic check_ball(input string name, input int col, input int row);
    analyze_frame();
    check({name, " ball count"}, 1, ball_count);
    check({name, " ball col"}, col, ball_col);
    check({name, " ball row"}, row, ball_row);
    check({name, " stray pixels"}, 0, stray_count);
  endtask

  // advances the reference ball by one frame.
  task automatic step_model();
    int dc;
    int dr;
    int miss;
    dc = m_dc;
    dr = m_dr;
    miss = 0;
    if (m_row == 0) dr = 1;
    else if (m_row == AR - 1) dr = 0;
    if (m_col == 1) begin
      if (m_row >= t1 && m_row < t1 + PH) dc = 1;
      else miss = 1;
    end else if (m_col == AC - 2) begin
      if (m_row >= t2 && m_row < t2 + PH) dc = 0;
      else miss = 1;
    end
    if (miss) begin
      m_play = 0;
      m_col = AC / 2;
      m_row = AR / 2;
    end else begin
      m_dc = dc;
      m_dr = dr;
      m_col = dc ? m_col + 1 : m_col - 1;
      m_row = dr ? m_row + 1 : m_row - 1;
    end
  endtask

  task automatic send_byte(input logic [7:0] data, input logic stop);
    @(negedge i_clk) i_uart_rx = 1'b0;
    repeat (4) @(negedge i_clk);
    for (int b = 0; b < 8; b++) begin
      i_uart_rx = data[b];
      repeat (4) @(negedge i_clk);
    end
    i_uart_rx = stop;
    repeat (4) @(negedge i_clk);
    i_uart_rx = 1'b1;
    repeat (8) @(negedge i_clk);
  endtask

  // serves the ball and follows the model until the ball is lost.
  task automatic play_rally(input string name, output int max_col);
    int waited;
    int frames;
    int bottom;
    waited = 0;
    frames = 0;
    bottom = 0;
    max_col = 0;
    send_byte(8'($random(seed)), 1'b1);
    do begin
      wait_frames(1);
      analyze_frame();
      waited++;
    end while (ball_col == AC / 2 && ball_row == AR / 2 && waited < 3);
    m_play = 1;
    m_col = AC / 2;
    m_row = AR / 2;
    m_dc = 1;
    m_dr = 1;
    step_model();
    check_ball(name, m_col, m_row);
    while (m_play && frames < 60) begin
      wait_frames(1);
      step_model();
      check_ball(name, m_col, m_row);
      if (ball_count == 1 && ball_row == AR - 1) bottom = 1;
      if (ball_count == 1 && ball_col > max_col) max_col = ball_col;
      frames++;
    end
    check({name, " bottom bounce seen"}, 1, bottom);
    check({name, " back in idle"}, 1,
          (ball_count == 1 && ball_col == AC / 2 && ball_row == AR / 2) ? 1 : 0);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %s: %s", name, (test_errors == 0) ? "ok" : "failed");
    test_errors = 0;
  endtask

  task automatic timing_test();
    wait_frames(2);
    check("timing line period", TC, last_line_len);
    check("timing hsync width", 4, last_low_width);
    check("timing lines per frame", TR, last_lines);
    check("timing blanking colour", 0, outside_errors);
    finish_test("timing");
  endtask

  task automatic idle_test();
    for (int f = 0; f < 3; f++) begin
      wait_frames(1);
      check_ball("idle", AC / 2, AR / 2);
      check("idle paddle 1 top", 9, p1_top);
      check("idle paddle 1 height", PH, p1_len);
      check("idle paddle 2 top", 9, p2_top);
      check("idle paddle 2 height", PH, p2_len);
    end
    finish_test("idle");
  endtask

  task automatic clamp_test();
    @(negedge i_clk) i_switch_1 = 1'b1;
    wait_frames(12);
    @(negedge i_clk) i_switch_1 = 1'b0;
    i_switch_4 = 1'b1;
    wait_frames(12);
    @(negedge i_clk) i_switch_4 = 1'b0;
    wait_frames(2);
    analyze_frame();
    check("clamp paddle 1 top", 0, p1_top);
    check("clamp paddle 1 height", PH, p1_len);
    check("clamp paddle 2 top", AR - PH, p2_top);
    check("clamp paddle 2 height", PH, p2_len);
    t1 = 0;
    t2 = AR - PH;
    finish_test("clamp");
  endtask

  task automatic serve_test();
    int max_col;
    play_rally("serve", max_col);
    finish_test("serve");
  endtask

  task automatic miss_test();
    int max_col;
    @(negedge i_clk) i_switch_3 = 1'b1;
    wait_frames(20);
    @(negedge i_clk) i_switch_3 = 1'b0;
    wait_frames(1);
    analyze_frame();
    check("miss paddle 2 top", 0, p2_top);
    t2 = 0;
    play_rally("miss", max_col);
    check("miss widest column", AC - 2, max_col);
    for (int f = 0; f < 3; f++) begin
      wait_frames(1);
      check_ball("miss rest", AC / 2, AR / 2);
    end
    finish_test("miss");
  endtask

  task automatic framing_test();
    send_byte(8'h55, 1'b0);
    for (int f = 0; f < 3; f++) begin
      wait_frames(1);
      check_ball("framing", AC / 2, AR / 2);
    end
    finish_test("framing");
  endtask

  initial begin
    seed = 4;
    i_clk = 1'b0;
    i_reset = 1'b1;
    i_uart_rx = 1'b1;
    i_switch_1 = 1'b0;
    i_switch_2 = 1'b0;
    i_switch_3 = 1'b0;
    i_switch_4 = 1'b0;
    repeat (5) @(negedge i_clk);
    i_reset = 1'b0;
    wait_frames(2);
    timing_test();
    idle_test();
    clamp_test();
    serve_test();
    miss_test();
    framing_test();
    $display("tests run: %0d, tests failed: %0d, checks failed: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* pong.f */
pong_pkg.sv
debounce_switch.sv
uart_rx.sv
sync_pulse.sv
pong_paddle.sv
game_main.sv
sync_porch.sv
pong_main.sv
pong_main_assert.sv
pong_main_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pong testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pong.f --top-module pong_main_tb \
  -o pong_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/pong_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Result: PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
